//--- miner_pkg.sv
// SHA-256 nonce miner package.
// Widths, register map, lane count, controller states and the SHA-256 tables
// shared by the register file, controller, counter and hash workers.
package miner_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] nonce_t;
	typedef logic [15:0] step_t;
	typedef logic [7:0]  apb_addr_t;
	typedef logic [1:0]  lane_idx_t;

	localparam int HEADER_WORDS = 11;
	localparam int NUM_LANES    = 4;
	localparam int ROUNDS       = 64;
	localparam int MSG_BITS     = 384; // header plus nonce, in bits.

	typedef word_t header_t [HEADER_WORDS];

	// APB register map, byte addresses.
	localparam apb_addr_t ADDR_HEADER = 8'h00; // 11 words up to 0x28.
	localparam apb_addr_t ADDR_TARGET = 8'h2C;
	localparam apb_addr_t ADDR_START  = 8'h30;
	localparam apb_addr_t ADDR_STEPS  = 8'h34;
	localparam apb_addr_t ADDR_CTRL   = 8'h38; // bit 0 starts a job.
	localparam apb_addr_t ADDR_STATUS = 8'h3C; // busy, done, found from bit 0.
	localparam apb_addr_t ADDR_RESULT = 8'h40;

	typedef enum logic [1:0] {
		IDLE,
		HASH,
		CHECK,
		DONE
	} ctrl_state_t;

	localparam word_t SHA_K [ROUNDS] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	localparam word_t SHA_H0 [8] = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

//--- miner_cfg_if.sv
// Miner job configuration.
// Carries header, target, start nonce, step count and the go pulse from the
// register file to the controller, the nonce counter and the hash lanes.
`timescale 1ns/1ps

interface miner_cfg_if;

	miner_pkg::header_t header;
	miner_pkg::word_t   target;
	miner_pkg::nonce_t  start_nonce;
	miner_pkg::step_t   steps;
	logic               go; // one cycle pulse per job.

	modport regs (
		output header, target, start_nonce, steps, go
	);

	modport ctrl (
		input header, target, start_nonce, steps, go
	);

	modport lane (
		input header, target
	);

endinterface

//--- apb_miner_regs.sv
// APB register file of the miner.
// Holds the job configuration, returns status and result, and issues go.
`timescale 1ns/1ps

module apb_miner_regs
(
	input  logic                  clk_i,
	input  logic                  reset_i,
	input  logic                  psel_i,
	input  logic                  penable_i,
	input  logic                  pwrite_i,
	input  miner_pkg::apb_addr_t  paddr_i,
	input  miner_pkg::word_t      pwdata_i,
	input  logic                  busy_i,
	input  logic                  done_i,
	input  logic                  found_i,
	input  miner_pkg::nonce_t     result_i,
	output miner_pkg::word_t      prdata_o,
	output logic                  pready_o,
	output logic                  pslverr_o,
	miner_cfg_if.regs             cfg
);

	logic       access;
	logic       addr_ok;
	logic       is_header;
	logic       is_cfg;
	logic       wr_ok;
	logic [3:0] hdr_idx;

	assign access    = psel_i & penable_i;
	assign is_header = paddr_i < miner_pkg::ADDR_TARGET;
	assign hdr_idx   = paddr_i[5:2];
	assign addr_ok   = (paddr_i[1:0] == 2'b00) && (paddr_i <= miner_pkg::ADDR_RESULT);
	assign is_cfg    = is_header || (paddr_i == miner_pkg::ADDR_TARGET) ||
		(paddr_i == miner_pkg::ADDR_START) || (paddr_i == miner_pkg::ADDR_STEPS);

	// config and start writes are refused while a job runs.
	assign pslverr_o = access & (!addr_ok |
		(pwrite_i & busy_i & (is_cfg | (paddr_i == miner_pkg::ADDR_CTRL))));
	assign wr_ok     = access & pwrite_i & !pslverr_o;
	assign pready_o  = 1'b1; // every access completes in one cycle.

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
				cfg.header[i] <= '0;
			cfg.target      <= '0;
			cfg.start_nonce <= '0;
			cfg.steps       <= '0;
			cfg.go          <= 1'b0;
		end
		else
		begin
			cfg.go <= wr_ok && (paddr_i == miner_pkg::ADDR_CTRL) && pwdata_i[0];
			if (wr_ok && is_header)
				cfg.header[hdr_idx] <= pwdata_i;
			if (wr_ok && (paddr_i == miner_pkg::ADDR_TARGET))
				cfg.target <= pwdata_i;
			if (wr_ok && (paddr_i == miner_pkg::ADDR_START))
				cfg.start_nonce <= pwdata_i;
			if (wr_ok && (paddr_i == miner_pkg::ADDR_STEPS))
				cfg.steps <= pwdata_i[15:0];
		end
	end

	always_comb
	begin
		if (is_header)
			prdata_o = cfg.header[hdr_idx];
		else
		begin
			case (paddr_i)
				miner_pkg::ADDR_TARGET: prdata_o = cfg.target;
				miner_pkg::ADDR_START:  prdata_o = cfg.start_nonce;
				miner_pkg::ADDR_STEPS:  prdata_o = {16'b0, cfg.steps};
				miner_pkg::ADDR_STATUS: prdata_o = {29'b0, found_i, done_i, busy_i};
				miner_pkg::ADDR_RESULT: prdata_o = result_i;
				default:                prdata_o = '0; // ctrl reads as zero.
			endcase
		end
	end

endmodule

//--- miner_ctrl.sv
// Miner job controller.
// Steps the lanes through the nonce span, picks the lowest hitting lane and
// records the winning nonce.
`timescale 1ns/1ps

module miner_ctrl
(
	input  logic                              clk_i,
	input  logic                              reset_i,
	input  logic                              last_step_i,
	input  miner_pkg::nonce_t                 base_nonce_i,
	input  logic                              lane_done_i,
	input  logic [miner_pkg::NUM_LANES-1:0]   lane_hit_i,
	miner_cfg_if.ctrl                         cfg,
	output logic                              load_o,
	output logic                              advance_o,
	output logic                              lane_start_o,
	output logic                              busy_o,
	output logic                              done_o,
	output logic                              found_o,
	output miner_pkg::nonce_t                 result_o
);

	miner_pkg::ctrl_state_t state_q;
	miner_pkg::ctrl_state_t state_d;
	miner_pkg::lane_idx_t   hit_idx;
	logic                   any_hit;
	logic                   finish;

	// lowest lane wins, since it holds the smallest nonce of the step.
	always_comb
	begin
		hit_idx = '0;
		for (int i = miner_pkg::NUM_LANES - 1; i >= 0; i--)
			if (lane_hit_i[i])
				hit_idx = miner_pkg::lane_idx_t'(i);
	end

	assign any_hit = |lane_hit_i;
	assign finish  = any_hit | last_step_i;

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			miner_pkg::IDLE,
			miner_pkg::DONE:  if (cfg.go) state_d = miner_pkg::HASH;
			miner_pkg::HASH:  if (lane_done_i) state_d = miner_pkg::CHECK;
			miner_pkg::CHECK: state_d = finish ? miner_pkg::DONE : miner_pkg::HASH;
			default:          state_d = miner_pkg::IDLE;
		endcase
	end

	assign load_o    = cfg.go && ((state_q == miner_pkg::IDLE) || (state_q == miner_pkg::DONE));
	assign advance_o = (state_q == miner_pkg::CHECK) && !finish;
	assign busy_o    = (state_q == miner_pkg::HASH) || (state_q == miner_pkg::CHECK);
	assign done_o    = state_q == miner_pkg::DONE;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			state_q      <= miner_pkg::IDLE;
			lane_start_o <= 1'b0;
			found_o      <= 1'b0;
			result_o     <= '0;
		end
		else
		begin
			state_q      <= state_d;
			lane_start_o <= (state_d == miner_pkg::HASH) && (state_q != miner_pkg::HASH);
			if (load_o)
				found_o <= 1'b0;
			if ((state_q == miner_pkg::CHECK) && any_hit)
			begin
				found_o  <= 1'b1;
				result_o <= base_nonce_i + miner_pkg::nonce_t'(hit_idx);
			end
		end
	end

endmodule

//--- nonce_counter.sv
// Nonce step counter.
// Produces the base nonce of each search step and flags the last step.
`timescale 1ns/1ps

module nonce_counter
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              load_i,
	input  logic              advance_i,
	miner_cfg_if.ctrl         cfg,
	output miner_pkg::nonce_t base_nonce_o,
	output logic              last_step_o
);

	miner_pkg::step_t step_idx;
	miner_pkg::step_t last_idx;

	// a zero step count still runs one step.
	assign last_idx    = (cfg.steps == '0) ? '0 : cfg.steps - 1'b1;
	assign last_step_o = step_idx == last_idx;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			base_nonce_o <= '0;
			step_idx     <= '0;
		end
		else if (load_i)
		begin
			base_nonce_o <= cfg.start_nonce;
			step_idx     <= '0;
		end
		else if (advance_i)
		begin
			base_nonce_o <= base_nonce_o + miner_pkg::nonce_t'(miner_pkg::NUM_LANES);
			step_idx     <= step_idx + 1'b1;
		end
	end

endmodule

//--- sha256_core.sv
// Single block SHA-256 worker.
// Hashes header plus nonce one round per cycle and compares digest word 0
// against the target.
`timescale 1ns/1ps

module sha256_core
(
	input  logic              clk_i,
	input  logic              reset_i,
	input  logic              start_i,
	input  miner_pkg::nonce_t nonce_i,
	miner_cfg_if.lane         cfg,
	output logic              done_o,
	output logic              hit_o
);

	miner_pkg::word_t a, b, c, d, e, f, g, h;
	miner_pkg::word_t w [16]; // w[0] is the word of the current round.
	miner_pkg::word_t t1;
	miner_pkg::word_t t2;
	miner_pkg::word_t w_next;
	miner_pkg::word_t digest0;
	logic [6:0]       round_q;
	logic             running_q;
	logic             hit_q;
	logic             hit_now;

	function automatic miner_pkg::word_t rotr(input miner_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	always_comb
	begin
		t1 = h + (rotr(e, 6) ^ rotr(e, 11) ^ rotr(e, 25)) + ((e & f) ^ (~e & g)) +
			miner_pkg::SHA_K[round_q[5:0]] + w[0];
		t2 = (rotr(a, 2) ^ rotr(a, 13) ^ rotr(a, 22)) + ((a & b) ^ (a & c) ^ (b & c));
		w_next = (rotr(w[14], 17) ^ rotr(w[14], 19) ^ (w[14] >> 10)) + w[9] +
			(rotr(w[1], 7) ^ rotr(w[1], 18) ^ (w[1] >> 3)) + w[0];
	end

	// Only word 0 of the digest takes part in the target compare.
	assign digest0 = a + miner_pkg::SHA_H0[0];
	assign hit_now = digest0 < cfg.target;
	assign done_o  = running_q && (round_q == miner_pkg::ROUNDS);
	assign hit_o   = done_o ? hit_now : hit_q;

	always_ff @(posedge clk_i)
	begin
		if (reset_i)
		begin
			running_q <= 1'b0;
			round_q   <= '0;
			hit_q     <= 1'b0;
		end
		else if (start_i)
		begin
			running_q <= 1'b1;
			round_q   <= '0;
			hit_q     <= 1'b0;
		end
		else if (running_q)
		begin
			if (round_q == miner_pkg::ROUNDS)
			begin
				running_q <= 1'b0; // final add cycle.
				hit_q     <= hit_now;
			end
			else
				round_q <= round_q + 1'b1;
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (start_i)
		begin
			{a, b, c, d} <= {miner_pkg::SHA_H0[0], miner_pkg::SHA_H0[1],
				miner_pkg::SHA_H0[2], miner_pkg::SHA_H0[3]};
			{e, f, g, h} <= {miner_pkg::SHA_H0[4], miner_pkg::SHA_H0[5],
				miner_pkg::SHA_H0[6], miner_pkg::SHA_H0[7]};
			for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
				w[i] <= cfg.header[i];
			w[miner_pkg::HEADER_WORDS] <= nonce_i;
			w[12] <= 32'h80000000; // padding marker bit.
			w[13] <= '0;
			w[14] <= '0;
			w[15] <= miner_pkg::word_t'(miner_pkg::MSG_BITS);
		end
		else if (running_q && (round_q < miner_pkg::ROUNDS))
		begin
			h <= g;
			g <= f;
			f <= e;
			e <= d + t1;
			d <= c;
			c <= b;
			b <= a;
			a <= t1 + t2;
			for (int i = 0; i < 15; i++)
				w[i] <= w[i + 1];
			w[15] <= w_next;
		end
	end

endmodule

//--- sha_miner_top.sv
// SHA-256 nonce search miner, top level.
// APB register file, job controller, nonce counter and the parallel hash lanes.
`timescale 1ns/1ps

module sha_miner_top
(
	input  logic                 clk_i,
	input  logic                 reset_i,
	input  logic                 psel_i,
	input  logic                 penable_i,
	input  logic                 pwrite_i,
	input  miner_pkg::apb_addr_t paddr_i,
	input  miner_pkg::word_t     pwdata_i,
	output miner_pkg::word_t     prdata_o,
	output logic                 pready_o,
	output logic                 pslverr_o
);

	miner_pkg::nonce_t                   base_nonce;
	miner_pkg::nonce_t                   result;
	miner_pkg::nonce_t                   lane_nonce [miner_pkg::NUM_LANES];
	logic                                last_step;
	logic                                load;
	logic                                advance;
	logic                                lane_start;
	logic                                busy;
	logic                                done;
	logic                                found;
	logic [miner_pkg::NUM_LANES-1:0]     lane_done;
	logic [miner_pkg::NUM_LANES-1:0]     lane_hit;

	miner_cfg_if cfg ();

	apb_miner_regs u_regs (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.busy_i    (busy),
		.done_i    (done),
		.found_i   (found),
		.result_i  (result),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o),
		.cfg       (cfg.regs)
	);

	miner_ctrl u_ctrl (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.last_step_i  (last_step),
		.base_nonce_i (base_nonce),
		.lane_done_i  (lane_done[0]), // lanes run in lockstep.
		.lane_hit_i   (lane_hit),
		.cfg          (cfg.ctrl),
		.load_o       (load),
		.advance_o    (advance),
		.lane_start_o (lane_start),
		.busy_o       (busy),
		.done_o       (done),
		.found_o      (found),
		.result_o     (result)
	);

	nonce_counter u_counter (
		.clk_i        (clk_i),
		.reset_i      (reset_i),
		.load_i       (load),
		.advance_i    (advance),
		.cfg          (cfg.ctrl),
		.base_nonce_o (base_nonce),
		.last_step_o  (last_step)
	);

	for (genvar i = 0; i < miner_pkg::NUM_LANES; i++)
	begin : g_lane
		assign lane_nonce[i] = base_nonce + miner_pkg::nonce_t'(i);

		sha256_core u_core (
			.clk_i   (clk_i),
			.reset_i (reset_i),
			.start_i (lane_start),
			.nonce_i (lane_nonce[i]),
			.cfg     (cfg.lane),
			.done_o  (lane_done[i]),
			.hit_o   (lane_hit[i])
		);
	end

endmodule

//--- sha_miner_sva.sv
// Miner assertions.
// Checks job start, the found flag, lane start timing and refused APB writes.
`timescale 1ns/1ps

module sha_miner_sva
(
	input logic                   clk_i,
	input logic                   reset_i,
	input logic                   psel_i,
	input logic                   penable_i,
	input logic                   pwrite_i,
	input logic                   pslverr_i,
	input logic                   go_i,
	input miner_pkg::word_t       target_i,
	input logic                   busy_i,
	input logic                   done_i,
	input logic                   found_i,
	input logic                   lane_start_i,
	input miner_pkg::ctrl_state_t state_i
);

	// a start pulse leaves done behind and shows busy on the next cycle.
	go_starts_job: assert property (@(posedge clk_i) disable iff (reset_i)
		go_i |=> (busy_i && !done_i))
		else $error("a job start did not move the controller from done to busy");

	found_needs_done: assert property (@(posedge clk_i) disable iff (reset_i)
		found_i |-> done_i)
		else $error("found is high without done");

	refused_write_no_effect: assert property (@(posedge clk_i) disable iff (reset_i)
		(psel_i && penable_i && pwrite_i && pslverr_i) |=> ($stable(target_i) && !go_i))
		else $error("a refused APB write changed the configuration");

	start_not_in_check: assert property (@(posedge clk_i) disable iff (reset_i)
		lane_start_i |-> (state_i != miner_pkg::CHECK))
		else $error("lane start issued in the check state");

endmodule

bind sha_miner_top sha_miner_sva u_sva (
	.clk_i        (clk_i),
	.reset_i      (reset_i),
	.psel_i       (psel_i),
	.penable_i    (penable_i),
	.pwrite_i     (pwrite_i),
	.pslverr_i    (pslverr_o),
	.go_i         (cfg.go),
	.target_i     (cfg.target),
	.busy_i       (busy),
	.done_i       (done),
	.found_i      (found),
	.lane_start_i (lane_start),
	.state_i      (u_ctrl.state_q)
);

//--- sha_miner_tb.sv
// Testbench for the SHA-256 nonce miner.
// Drives jobs over APB and compares status and result with a reference search.
`timescale 1ns/1ps

module sha_miner_tb;

	localparam int SEED            = 93413;
	localparam int HIT_STEPS       = 8;
	localparam int MISS_STEPS      = 3;
	localparam int BUSY_STEPS      = 4;
	localparam int RAND_STEPS      = 6;
	localparam int RAND_JOBS       = 3;
	localparam int CYCLES_PER_STEP = 67; // 65 hash cycles, check, restart.
	localparam int TOTAL_STEPS     = HIT_STEPS + MISS_STEPS + BUSY_STEPS + RAND_JOBS * RAND_STEPS;
	localparam int WATCHDOG_CYCLES = TOTAL_STEPS * CYCLES_PER_STEP + 2000;

	logic                 clk_i;
	logic                 reset_i;
	logic                 psel_i;
	logic                 penable_i;
	logic                 pwrite_i;
	miner_pkg::apb_addr_t paddr_i;
	miner_pkg::word_t     pwdata_i;
	miner_pkg::word_t     prdata_o;
	logic                 pready_o;
	logic                 pslverr_o;

	miner_pkg::header_t   job_hdr;
	miner_pkg::word_t     job_target;
	miner_pkg::nonce_t    job_start;
	miner_pkg::step_t     job_steps;
	int                   mismatch_count;
	int                   other_errors;
	event                 job_started;
	event                 job_checked;

	sha_miner_top uut (
		.clk_i     (clk_i),
		.reset_i   (reset_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o)
	);

	initial clk_i = 1'b0;
	always #50 clk_i = ~clk_i;

	function automatic miner_pkg::word_t rotate_right(input miner_pkg::word_t x, input int n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// digest word 0 of the one block message made of header, nonce and padding.
	function automatic miner_pkg::word_t ref_sha_word0(input miner_pkg::header_t hdr,
		input miner_pkg::nonce_t nonce);
		miner_pkg::word_t w [64];
		miner_pkg::word_t a, b, c, d, e, f, g, h;
		miner_pkg::word_t s0, s1, t1, t2;
		for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
			w[i] = hdr[i];
		w[11] = nonce;
		w[12] = 32'h80000000;
		w[13] = '0;
		w[14] = '0;
		w[15] = miner_pkg::word_t'(miner_pkg::MSG_BITS);
		for (int i = 16; i < 64; i++)
		begin
			s0   = rotate_right(w[i-15], 7) ^ rotate_right(w[i-15], 18) ^ (w[i-15] >> 3);
			s1   = rotate_right(w[i-2], 17) ^ rotate_right(w[i-2], 19) ^ (w[i-2] >> 10);
			w[i] = w[i-16] + s0 + w[i-7] + s1;
		end
		a = miner_pkg::SHA_H0[0];
		b = miner_pkg::SHA_H0[1];
		c = miner_pkg::SHA_H0[2];
		d = miner_pkg::SHA_H0[3];
		e = miner_pkg::SHA_H0[4];
		f = miner_pkg::SHA_H0[5];
		g = miner_pkg::SHA_H0[6];
		h = miner_pkg::SHA_H0[7];
		for (int i = 0; i < 64; i++)
		begin
			s1 = rotate_right(e, 6) ^ rotate_right(e, 11) ^ rotate_right(e, 25);
			t1 = h + s1 + ((e & f) ^ (~e & g)) + miner_pkg::SHA_K[i] + w[i];
			s0 = rotate_right(a, 2) ^ rotate_right(a, 13) ^ rotate_right(a, 22);
			t2 = s0 + ((a & b) ^ (a & c) ^ (b & c));
			h  = g;
			g  = f;
			f  = e;
			e  = d + t1;
			d  = c;
			c  = b;
			b  = a;
			a  = t1 + t2;
		end
		return a + miner_pkg::SHA_H0[0];
	endfunction

	// first nonce of the span whose word 0 is below target.
	function automatic logic ref_search(input miner_pkg::header_t hdr, input miner_pkg::word_t target,
		input miner_pkg::nonce_t start, input miner_pkg::step_t steps,
		output miner_pkg::nonce_t nonce);
		int                count;
		logic              hit;
		miner_pkg::nonce_t cand;
		hit   = 1'b0;
		nonce = '0;
		count = (steps == '0) ? miner_pkg::NUM_LANES : int'(steps) * miner_pkg::NUM_LANES;
		for (int n = 0; (n < count) && !hit; n++)
		begin
			cand = start + miner_pkg::nonce_t'(n);
			if (ref_sha_word0(hdr, cand) < target)
			begin
				hit   = 1'b1;
				nonce = cand;
			end
		end
		return hit;
	endfunction

	task automatic check_word(input miner_pkg::word_t got, input miner_pkg::word_t exp,
		input string what);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_nonce(input miner_pkg::nonce_t got, input miner_pkg::nonce_t exp,
		input string what);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			mismatch_count++;
			$display("Mismatch at time %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic expect_slverr(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			other_errors++;
			if (exp)
				$display("%s: the DUT did not signal pslverr", what);
			else
				$display("%s: the DUT signalled pslverr where none was expected", what);
		end
	endtask

	// setup cycle, then access cycle; response sampled mid access cycle.
	task automatic apb_write(input miner_pkg::apb_addr_t addr, input miner_pkg::word_t data,
		output logic err);
		@(posedge clk_i);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b1;
		paddr_i   <= addr;
		pwdata_i  <= data;
		@(posedge clk_i);
		penable_i <= 1'b1;
		@(negedge clk_i);
		err = pslverr_o;
		check_flag(pready_o, 1'b1, "pready in write access cycle");
		@(posedge clk_i);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic apb_read(input miner_pkg::apb_addr_t addr, output miner_pkg::word_t data,
		output logic err);
		@(posedge clk_i);
		psel_i    <= 1'b1;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
		paddr_i   <= addr;
		@(posedge clk_i);
		penable_i <= 1'b1;
		@(negedge clk_i);
		err  = pslverr_o;
		data = prdata_o;
		check_flag(pready_o, 1'b1, "pready in read access cycle");
		@(posedge clk_i);
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
	endtask

	task automatic write_reg(input miner_pkg::apb_addr_t addr, input miner_pkg::word_t data,
		input string what);
		logic err;
		apb_write(addr, data, err);
		expect_slverr(err, 1'b0, what);
	endtask

	task automatic read_reg(input miner_pkg::apb_addr_t addr, output miner_pkg::word_t data,
		input string what);
		logic err;
		apb_read(addr, data, err);
		expect_slverr(err, 1'b0, what);
	endtask

	function automatic miner_pkg::apb_addr_t header_addr(input int i);
		return miner_pkg::apb_addr_t'(int'(miner_pkg::ADDR_HEADER) + 4 * i);
	endfunction

	task automatic randomize_header();
		for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
			job_hdr[i] = $urandom;
	endtask

	task automatic program_job();
		for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
			write_reg(header_addr(i), job_hdr[i], $sformatf("header word %0d write", i));
		write_reg(miner_pkg::ADDR_TARGET, job_target, "target write");
		write_reg(miner_pkg::ADDR_START, job_start, "start nonce write");
		write_reg(miner_pkg::ADDR_STEPS, {16'h0000, job_steps}, "step count write");
	endtask

	task automatic start_job();
		write_reg(miner_pkg::ADDR_CTRL, 32'h1, "job start");
	endtask

	task automatic await_job_check();
		-> job_started;
		@(job_checked);
	endtask

	// waits for done, then compares found and the winning nonce.
	always @(job_started)
	begin : compare_job
		logic              ref_found;
		miner_pkg::nonce_t ref_nonce;
		miner_pkg::word_t  status;
		miner_pkg::word_t  result;
		ref_found = ref_search(job_hdr, job_target, job_start, job_steps, ref_nonce);
		status = '0;
		while (!status[1])
			read_reg(miner_pkg::ADDR_STATUS, status, "status poll");
		check_flag(status[0], 1'b0, "busy at job end");
		check_flag(status[2], ref_found, "found flag");
		if (ref_found)
		begin
			read_reg(miner_pkg::ADDR_RESULT, result, "result read");
			check_nonce(result, ref_nonce, "winning nonce");
		end
		-> job_checked;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("watchdog expired after %0d cycles, the DUT never finished", WATCHDOG_CYCLES);
		$display("tests failed");
		$finish;
	end

	initial
	begin
		miner_pkg::word_t rd;
		logic             err;
		void'($urandom(SEED));
		mismatch_count = 0;
		other_errors   = 0;
		reset_i   <= 1'b1;
		psel_i    <= 1'b0;
		penable_i <= 1'b0;
		pwrite_i  <= 1'b0;
		paddr_i   <= '0;
		pwdata_i  <= '0;
		repeat (16) @(posedge clk_i);
		reset_i <= 1'b0;

		// register reset values and read back.
		read_reg(miner_pkg::ADDR_STATUS, rd, "status read");
		check_word(rd, '0, "status after reset");
		read_reg(miner_pkg::ADDR_RESULT, rd, "result read");
		check_word(rd, '0, "result after reset");
		randomize_header();
		job_target = $urandom;
		job_start  = $urandom;
		job_steps  = miner_pkg::step_t'($urandom);
		program_job();
		for (int i = 0; i < miner_pkg::HEADER_WORDS; i++)
		begin
			read_reg(header_addr(i), rd, "header read");
			check_word(rd, job_hdr[i], $sformatf("header word %0d", i));
		end
		read_reg(miner_pkg::ADDR_TARGET, rd, "target read");
		check_word(rd, job_target, "target");
		read_reg(miner_pkg::ADDR_START, rd, "start nonce read");
		check_word(rd, job_start, "start nonce");
		read_reg(miner_pkg::ADDR_STEPS, rd, "step count read");
		check_word(rd, {16'h0000, job_steps}, "step count");

		// an easy target makes a hit within the span likely.
		randomize_header();
		job_target = 32'h20000000;
		job_start  = $urandom;
		job_steps  = miner_pkg::step_t'(HIT_STEPS);
		program_job();
		start_job();
		await_job_check();

		// nothing is below zero, so all steps run without a hit.
		job_target = '0;
		job_steps  = miner_pkg::step_t'(MISS_STEPS);
		program_job();
		start_job();
		await_job_check();

		job_steps = miner_pkg::step_t'(BUSY_STEPS);
		program_job();
		start_job();
		apb_write(miner_pkg::ADDR_TARGET, 32'hffffffff, err);
		expect_slverr(err, 1'b1, "target write while busy");
		apb_read(8'h80, rd, err);
		expect_slverr(err, 1'b1, "read of unmapped address 0x80");
		await_job_check();
		read_reg(miner_pkg::ADDR_TARGET, rd, "target read");
		check_word(rd, '0, "target after refused write");

		for (int j = 0; j < RAND_JOBS; j++)
		begin
			randomize_header();
			job_target = 32'h10000000;
			job_start  = $urandom;
			job_steps  = miner_pkg::step_t'(RAND_STEPS);
			program_job();
			start_job();
			await_job_check();
		end

		$display("mismatches: %0d, other errors: %0d", mismatch_count, other_errors);
		if ((mismatch_count == 0) && (other_errors == 0))
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- sha_miner_top.f
miner_pkg.sv
miner_cfg_if.sv
apb_miner_regs.sv
miner_ctrl.sv
nonce_counter.sv
sha256_core.sv
sha_miner_top.sv
sha_miner_sva.sv
sha_miner_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f sha_miner_top.f --top-module sha_miner_tb
	@out="$$(./obj_dir/Vsha_miner_tb)"; echo "$$out"; echo "$$out" | grep -q "all tests passed"

clean:
	rm -rf obj_dir
